//--- cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W = 16;
	localparam int NUM_REGS = 8;
	localparam int REG_W = $clog2(NUM_REGS);
	localparam int IMM_W = 8;

	// Opcodes live in instruction bits 3:0
	localparam logic [3:0] OP_MV = 4'h0;
	localparam logic [3:0] OP_ADD = 4'h1;
	localparam logic [3:0] OP_SUB = 4'h2;
	localparam logic [3:0] OP_CMP = 4'h3;
	localparam logic [3:0] OP_LD = 4'h4;
	localparam logic [3:0] OP_ST = 4'h5;
	localparam logic [3:0] OP_MVHI = 4'h6;
	localparam logic [3:0] OP_J = 4'h8;
	localparam logic [3:0] OP_JZ = 4'h9;
	localparam logic [3:0] OP_JN = 4'ha;

	// One instruction word, seen as register form or immediate form
	typedef union packed {
		struct packed {
			logic [DATA_W-2*REG_W-6:0] rsvd;
			logic [REG_W-1:0] ry;
			logic [REG_W-1:0] rx;
			logic imm;
			logic [3:0] op;
		} r;
		struct packed {
			logic [IMM_W-1:0] imm8;
			logic [REG_W-1:0] rx;
			logic imm;
			logic [3:0] op;
		} i;
	} instr_t;

endpackage

//--- cpu_dx_if.sv
`timescale 1ns/10ps

interface cpu_dx_if import cpu_pkg::*; ();

	logic valid;
	logic [DATA_W-1:0] pc;
	instr_t ir;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;

	modport src (
		output valid,
		output pc,
		output ir,
		output op_a,
		output op_b
	);

	modport dst (
		input valid,
		input pc,
		input ir,
		input op_a,
		input op_b
	);

endinterface

//--- cpu_regfile.sv
`timescale 1ns/10ps

module cpu_regfile import cpu_pkg::*; (
	input clk,
	input i_rst_n,

	input [REG_W-1:0] i_rx,
	input [REG_W-1:0] i_ry,
	input [REG_W-1:0] i_rw,
	input [DATA_W-1:0] i_rw_data,
	input i_rw_en,

	output logic [DATA_W-1:0] o_rx_data,
	output logic [DATA_W-1:0] o_ry_data,
	output logic [NUM_REGS-1:0][DATA_W-1:0] o_regs
);

	logic [NUM_REGS-1:0][DATA_W-1:0] regs;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			regs <= '0;
		end else if (i_rw_en) begin
			regs[i_rw] <= i_rw_data;
		end
	end

	// Write-through so decode sees the value writeback is committing
	assign o_rx_data = (i_rw_en && i_rw == i_rx) ? i_rw_data : regs[i_rx];
	assign o_ry_data = (i_rw_en && i_rw == i_ry) ? i_rw_data : regs[i_ry];

	assign o_regs = regs;

endmodule

//--- cpu_fetch.sv
`timescale 1ns/10ps

module cpu_fetch import cpu_pkg::*; (
	input clk,
	input i_rst_n,

	input i_br_en,
	input [DATA_W-1:0] i_br_pc,

	output logic [DATA_W-1:0] o_pc_addr,
	output logic o_pc_rd,
	output logic [DATA_W-1:0] o_pc
);

	logic [DATA_W-1:0] pc_q;
	logic rd_q;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pc_q <= '0;
			rd_q <= 1'b0;
		end else begin
			rd_q <= 1'b1;
			if (i_br_en)
				pc_q <= i_br_pc;
			else if (rd_q)
				pc_q <= pc_q + 1'b1;
		end
	end

	// Address of the word now coming back from the instruction memory
	always_ff @(posedge clk) begin
		o_pc <= pc_q;
	end

	assign o_pc_addr = pc_q;
	assign o_pc_rd = rd_q;

endmodule

//--- cpu_decode.sv
`timescale 1ns/10ps

module cpu_decode import cpu_pkg::*; (
	input clk,
	input i_rst_n,
	input i_squash,

	input [DATA_W-1:0] i_pc,
	input [DATA_W-1:0] i_ir,
	input [DATA_W-1:0] i_rx_data,
	input [DATA_W-1:0] i_ry_data,

	output logic [REG_W-1:0] o_rx,
	output logic [REG_W-1:0] o_ry,

	cpu_dx_if.src dx
);

	instr_t word;
	logic [DATA_W-1:0] imm_ext;
	logic fetch_live;
	logic word_live;
	logic squash_q;

	assign word = i_ir;
	assign o_rx = word.r.rx;
	assign o_ry = word.r.ry;
	assign imm_ext = {{(DATA_W-IMM_W){word.i.imm8[IMM_W-1]}}, word.i.imm8};

	// First fetched word returns two cycles after reset is released
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			fetch_live <= 1'b0;
			word_live <= 1'b0;
			squash_q <= 1'b0;
			dx.valid <= 1'b0;
		end else begin
			fetch_live <= 1'b1;
			word_live <= fetch_live;
			squash_q <= i_squash;
			// Kill the word arriving now and the one still in flight
			dx.valid <= word_live & ~i_squash & ~squash_q;
		end
	end

	always_ff @(posedge clk) begin
		dx.pc <= i_pc;
		dx.ir <= word;
		dx.op_a <= i_rx_data;
		dx.op_b <= word.r.imm ? imm_ext : i_ry_data;
	end

endmodule

//--- cpu_execute.sv
`timescale 1ns/10ps

module cpu_execute import cpu_pkg::*; (
	input clk,
	input i_rst_n,

	cpu_dx_if.dst dx,

	input i_rw_en,
	input [REG_W-1:0] i_rw,
	input [DATA_W-1:0] i_rw_data,

	output logic o_br_en,
	output logic [DATA_W-1:0] o_br_pc,

	output logic [DATA_W-1:0] o_mem_addr,
	output logic o_mem_rd,
	output logic o_mem_wr,
	output logic [DATA_W-1:0] o_mem_wrdata,

	output logic o_valid,
	output instr_t o_ir,
	output logic [DATA_W-1:0] o_result
);

	logic [3:0] op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] diff;
	logic [DATA_W-1:0] flag_src;
	logic set_flags;
	logic take;
	logic n_q;
	logic z_q;

	assign op = dx.ir.r.op;

	// Bypass from writeback, only where the operand came from a register
	assign a = (i_rw_en && i_rw == dx.ir.r.rx) ? i_rw_data : dx.op_a;
	assign b = (i_rw_en && !dx.ir.r.imm && i_rw == dx.ir.r.ry) ? i_rw_data : dx.op_b;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		case (op)
			OP_ADD: o_result = sum;
			OP_SUB: o_result = diff;
			OP_MVHI: o_result = {dx.ir.i.imm8, a[DATA_W-IMM_W-1:0]};
			default: o_result = b;
		endcase
	end

	assign set_flags = dx.valid && (op == OP_ADD || op == OP_SUB || op == OP_CMP);
	assign flag_src = (op == OP_ADD) ? sum : diff;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			n_q <= 1'b0;
			z_q <= 1'b0;
		end else if (set_flags) begin
			n_q <= flag_src[DATA_W-1];
			z_q <= (flag_src == '0);
		end
	end

	always_comb begin
		case (op)
			OP_J: take = 1'b1;
			OP_JZ: take = z_q;
			OP_JN: take = n_q;
			default: take = 1'b0;
		endcase
	end

	// Immediate target is relative to the next word
	assign o_br_en = dx.valid & take;
	assign o_br_pc = dx.ir.r.imm ? dx.pc + b + 1'b1 : a;

	assign o_mem_rd = dx.valid && op == OP_LD;
	assign o_mem_wr = dx.valid && op == OP_ST;
	assign o_mem_addr = b;
	assign o_mem_wrdata = a;

	assign o_valid = dx.valid;
	assign o_ir = dx.ir;

endmodule

//--- cpu_writeback.sv
`timescale 1ns/10ps

module cpu_writeback import cpu_pkg::*; (
	input clk,
	input i_rst_n,

	input i_valid,
	input instr_t i_ir,
	input [DATA_W-1:0] i_result,
	input [DATA_W-1:0] i_mem_rddata,

	output logic o_rw_en,
	output logic [REG_W-1:0] o_rw,
	output logic [DATA_W-1:0] o_rw_data
);

	logic valid_q;
	instr_t ir_q;
	logic [DATA_W-1:0] result_q;
	logic writes;

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= i_valid;
	end

	always_ff @(posedge clk) begin
		ir_q <= i_ir;
		result_q <= i_result;
	end

	always_comb begin
		case (ir_q.r.op)
			OP_MV, OP_ADD, OP_SUB, OP_MVHI, OP_LD: writes = 1'b1;
			default: writes = 1'b0;
		endcase
	end

	// Load data arrives one cycle after the read strobe
	assign o_rw_en = valid_q & writes;
	assign o_rw = ir_q.r.rx;
	assign o_rw_data = (ir_q.r.op == OP_LD) ? i_mem_rddata : result_q;

endmodule

//--- cpu.sv
`timescale 1ns/10ps

module cpu import cpu_pkg::*; (
	input clk,
	input i_rst_n,

	output logic [DATA_W-1:0] o_pc_addr,
	output logic o_pc_rd,
	input [DATA_W-1:0] i_pc_rddata,

	output logic [DATA_W-1:0] o_ldst_addr,
	output logic o_ldst_rd,
	output logic o_ldst_wr,
	output logic [DATA_W-1:0] o_ldst_wrdata,
	input [DATA_W-1:0] i_ldst_rddata,

	output logic [NUM_REGS-1:0][DATA_W-1:0] o_tb_regs
);

	logic [REG_W-1:0] rx;
	logic [REG_W-1:0] ry;
	logic [DATA_W-1:0] rx_data;
	logic [DATA_W-1:0] ry_data;

	logic rw_en;
	logic [REG_W-1:0] rw;
	logic [DATA_W-1:0] rw_data;

	logic br_en;
	logic [DATA_W-1:0] br_pc;
	logic [DATA_W-1:0] fetch_pc;

	logic ex_valid;
	instr_t ex_ir;
	logic [DATA_W-1:0] ex_result;

	cpu_dx_if dx_if ();

	cpu_regfile u_regfile (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_rx(rx),
		.i_ry(ry),
		.i_rw(rw),
		.i_rw_data(rw_data),
		.i_rw_en(rw_en),
		.o_rx_data(rx_data),
		.o_ry_data(ry_data),
		.o_regs(o_tb_regs)
	);

	cpu_fetch u_fetch (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_br_en(br_en),
		.i_br_pc(br_pc),
		.o_pc_addr(o_pc_addr),
		.o_pc_rd(o_pc_rd),
		.o_pc(fetch_pc)
	);

	cpu_decode u_decode (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_squash(br_en),
		.i_pc(fetch_pc),
		.i_ir(i_pc_rddata),
		.i_rx_data(rx_data),
		.i_ry_data(ry_data),
		.o_rx(rx),
		.o_ry(ry),
		.dx(dx_if.src)
	);

	cpu_execute u_execute (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.dx(dx_if.dst),
		.i_rw_en(rw_en),
		.i_rw(rw),
		.i_rw_data(rw_data),
		.o_br_en(br_en),
		.o_br_pc(br_pc),
		.o_mem_addr(o_ldst_addr),
		.o_mem_rd(o_ldst_rd),
		.o_mem_wr(o_ldst_wr),
		.o_mem_wrdata(o_ldst_wrdata),
		.o_valid(ex_valid),
		.o_ir(ex_ir),
		.o_result(ex_result)
	);

	cpu_writeback u_writeback (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_valid(ex_valid),
		.i_ir(ex_ir),
		.i_result(ex_result),
		.i_mem_rddata(i_ldst_rddata),
		.o_rw_en(rw_en),
		.o_rw(rw),
		.o_rw_data(rw_data)
	);

endmodule

//--- cpu_assertions.sv
`timescale 1ns/10ps

module cpu_assertions (
	input clk,
	input i_rst_n,
	input i_pc_rd,
	input i_ldst_rd,
	input i_ldst_wr
);

	// One data access per cycle
	strobe_exclusive: assert property (@(posedge clk) !(i_ldst_rd && i_ldst_wr))
		else $error("load and store strobes high in the same cycle");

	quiet_in_reset: assert property (@(posedge clk)
		(!i_rst_n && !$past(i_rst_n)) |-> !(i_ldst_rd || i_ldst_wr))
		else $error("data strobe high during reset");

	fetch_after_reset: assert property (@(posedge clk)
		(i_rst_n && $past(i_rst_n)) |-> i_pc_rd)
		else $error("instruction read strobe low after reset release");

endmodule

bind cpu cpu_assertions u_assertions (
	.clk(clk),
	.i_rst_n(i_rst_n),
	.i_pc_rd(o_pc_rd),
	.i_ldst_rd(o_ldst_rd),
	.i_ldst_wr(o_ldst_wr)
);

//--- cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker import cpu_pkg::*; (
	input clk,
	input i_rst_n,
	input [DATA_W-1:0] i_pc_addr,
	input i_pc_rd,
	input [DATA_W-1:0] i_ldst_addr,
	input i_ldst_rd,
	input i_ldst_wr,
	input [DATA_W-1:0] i_ldst_wrdata,
	input [NUM_REGS-1:0][DATA_W-1:0] i_tb_regs,
	input [NUM_REGS-1:0][DATA_W-1:0] i_exp_regs,
	input [DATA_W-1:0] i_exp_st_addr [256],
	input [DATA_W-1:0] i_exp_st_data [256],
	input int i_exp_st_count,
	input [DATA_W-1:0] i_end_pc,
	output logic o_done,
	output int o_errors
);

	int st_idx;
	int end_hits;
	int drain;
	int st_errs;
	int reg_errs;
	int other_errs;
	logic rst_q;

	initial begin
		o_done = 1'b0;
		o_errors = 0;
		st_idx = 0;
		end_hits = 0;
		drain = 0;
		st_errs = 0;
		reg_errs = 0;
		other_errs = 0;
		rst_q = 1'b0;
	end

	task automatic check_store();
		if (st_idx >= i_exp_st_count) begin
			$display("error: store to address %h beyond the expected %0d stores",
				i_ldst_addr, i_exp_st_count);
			st_errs++;
		end else begin
			if (i_ldst_addr != i_exp_st_addr[st_idx]) begin
				$display("mismatch o_ldst_addr: got %h expected %h (store %0d)",
					i_ldst_addr, i_exp_st_addr[st_idx], st_idx);
				st_errs++;
			end
			if (i_ldst_wrdata != i_exp_st_data[st_idx]) begin
				$display("mismatch o_ldst_wrdata: got %h expected %h (store %0d)",
					i_ldst_wrdata, i_exp_st_data[st_idx], st_idx);
				st_errs++;
			end
		end
		st_idx++;
	endtask

	task automatic final_compare();
		for (int i = 0; i < NUM_REGS; i++) begin
			if (i_tb_regs[i] != i_exp_regs[i]) begin
				$display("mismatch o_tb_regs[%0d]: got %h expected %h",
					i, i_tb_regs[i], i_exp_regs[i]);
				reg_errs++;
			end
		end
		if (st_idx != i_exp_st_count) begin
			$display("mismatch store count: got %h expected %h", st_idx, i_exp_st_count);
			st_errs++;
		end
		o_errors = st_errs + reg_errs + other_errs;
		$display("checker: %0d errors (%0d store, %0d register, %0d other), %0d stores seen",
			o_errors, st_errs, reg_errs, other_errs, st_idx);
		o_done = 1'b1;
	endtask

	// Outputs are sampled mid-cycle, away from the clock edge
	always @(negedge clk) begin
		if (!o_done) begin
			if (!i_rst_n || !rst_q) begin
				if (i_ldst_rd || i_ldst_wr) begin
					$display("error: data strobe high in reset or the cycle after it");
					other_errs++;
				end
				if (i_pc_addr != '0) begin
					$display("mismatch o_pc_addr: got %h expected %h", i_pc_addr, 16'h0);
					other_errs++;
				end
			end
			if (i_rst_n && i_ldst_wr)
				check_store();
			// Third fetch of the final jump means its self loop has run
			if (i_rst_n && i_pc_rd && i_pc_addr == i_end_pc && end_hits < 3)
				end_hits++;
			if (end_hits == 3) begin
				drain++;
				if (drain > 4)
					final_compare();
			end
			rst_q = i_rst_n;
		end
	end

endmodule

//--- tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

	localparam int RST_CYCLES = 16;
	localparam int PROG_LEN = 240;
	localparam int END_PC = PROG_LEN - 1;
	localparam int LIMIT_CYCLES = RST_CYCLES + 5 * PROG_LEN + 100;

	logic clk;
	logic rst_n;
	logic [DATA_W-1:0] pc_addr;
	logic pc_rd;
	logic [DATA_W-1:0] pc_rddata;
	logic [DATA_W-1:0] ldst_addr;
	logic ldst_rd;
	logic ldst_wr;
	logic [DATA_W-1:0] ldst_wrdata;
	logic [DATA_W-1:0] ldst_rddata;
	logic [NUM_REGS-1:0][DATA_W-1:0] tb_regs;

	logic [DATA_W-1:0] rom [256];
	logic [DATA_W-1:0] ram [256];
	logic [DATA_W-1:0] ram_init [256];

	logic [NUM_REGS-1:0][DATA_W-1:0] exp_regs;
	logic [DATA_W-1:0] exp_st_addr [256];
	logic [DATA_W-1:0] exp_st_data [256];
	int exp_st_count;
	int exp_steps;
	logic done;
	int errors;

	cpu u_dut (
		.clk(clk),
		.i_rst_n(rst_n),
		.o_pc_addr(pc_addr),
		.o_pc_rd(pc_rd),
		.i_pc_rddata(pc_rddata),
		.o_ldst_addr(ldst_addr),
		.o_ldst_rd(ldst_rd),
		.o_ldst_wr(ldst_wr),
		.o_ldst_wrdata(ldst_wrdata),
		.i_ldst_rddata(ldst_rddata),
		.o_tb_regs(tb_regs)
	);

	cpu_checker u_checker (
		.clk(clk),
		.i_rst_n(rst_n),
		.i_pc_addr(pc_addr),
		.i_pc_rd(pc_rd),
		.i_ldst_addr(ldst_addr),
		.i_ldst_rd(ldst_rd),
		.i_ldst_wr(ldst_wr),
		.i_ldst_wrdata(ldst_wrdata),
		.i_tb_regs(tb_regs),
		.i_exp_regs(exp_regs),
		.i_exp_st_addr(exp_st_addr),
		.i_exp_st_data(exp_st_data),
		.i_exp_st_count(exp_st_count),
		.i_end_pc(16'(END_PC)),
		.o_done(done),
		.o_errors(errors)
	);

	always #10 clk = ~clk;

	// Both memories answer one cycle after the strobe
	always @(posedge clk) begin
		if (pc_rd)
			pc_rddata <= rom[pc_addr[7:0]];
		if (ldst_wr)
			ram[ldst_addr[7:0]] <= ldst_wrdata;
		if (ldst_rd)
			ldst_rddata <= ram[ldst_addr[7:0]];
	end

	function automatic logic [3:0] pick_op(int k);
		case (k)
			0: return OP_MV;
			1: return OP_ADD;
			2: return OP_SUB;
			3: return OP_CMP;
			4: return OP_LD;
			5: return OP_ST;
			6: return OP_MVHI;
			7: return OP_J;
			8: return OP_JZ;
			default: return OP_JN;
		endcase
	endfunction

	task automatic fill_rom();
		instr_t w;
		int off;
		// Words past the program are only ever fetched into squashed slots
		for (int a = 0; a < 256; a++)
			rom[a] = {a[7:0], ~a[7:0]};
		for (int a = 0; a < END_PC; a++) begin
			w = 16'($urandom);
			w.r.op = pick_op($urandom_range(9, 0));
			case (w.r.op)
				OP_LD, OP_ST: w.r.imm = 1'b0;
				OP_MVHI: w.r.imm = 1'b1;
				OP_J, OP_JZ, OP_JN: begin
					// Forward only, never past the final jump
					w.r.imm = 1'b1;
					off = $urandom_range(7, 0);
					if (off > END_PC - a - 1)
						off = END_PC - a - 1;
					w.i.imm8 = off[7:0];
				end
				default: ;
			endcase
			rom[a] = w;
		end
		w = '0;
		w.i.op = OP_J;
		w.i.imm = 1'b1;
		w.i.imm8 = 8'hff;
		rom[END_PC] = w;
	endtask

	task automatic fill_ram();
		for (int a = 0; a < 256; a++) begin
			ram_init[a] = 16'($urandom);
			ram[a] <= ram_init[a];
		end
	endtask

	// Sequential execution of the program up to the final jump
	function automatic int run_model();
		logic [NUM_REGS-1:0][DATA_W-1:0] r;
		logic [DATA_W-1:0] mem [256];
		logic [DATA_W-1:0] pc;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] res;
		instr_t w;
		logic n;
		logic z;
		logic take;
		int steps;
		r = '0;
		mem = ram_init;
		pc = '0;
		n = 1'b0;
		z = 1'b0;
		steps = 0;
		exp_st_count = 0;
		while (pc != 16'(END_PC) && steps < 4 * PROG_LEN) begin
			w = rom[pc[7:0]];
			a = r[w.r.rx];
			b = w.r.imm ? {{8{w.i.imm8[7]}}, w.i.imm8} : r[w.r.ry];
			take = 1'b0;
			case (w.r.op)
				OP_MV: r[w.r.rx] = b;
				OP_ADD, OP_SUB, OP_CMP: begin
					res = (w.r.op == OP_ADD) ? a + b : a - b;
					n = res[15];
					z = (res == '0);
					if (w.r.op != OP_CMP)
						r[w.r.rx] = res;
				end
				OP_LD: r[w.r.rx] = mem[b[7:0]];
				OP_ST: begin
					mem[b[7:0]] = a;
					exp_st_addr[exp_st_count] = b;
					exp_st_data[exp_st_count] = a;
					exp_st_count++;
				end
				OP_MVHI: r[w.r.rx] = {w.i.imm8, a[7:0]};
				OP_J: take = 1'b1;
				OP_JZ: take = z;
				OP_JN: take = n;
				default: ;
			endcase
			if (take)
				pc = w.r.imm ? pc + 16'd1 + b : a;
			else
				pc = pc + 16'd1;
			steps++;
		end
		exp_regs = r;
		return steps;
	endfunction

	initial begin
		clk = 1'b0;
		rst_n <= 1'b0;
		pc_rddata <= '0;
		ldst_rddata <= '0;
		void'($urandom(32'h62d9_70c8));
		fill_rom();
		fill_ram();
		exp_steps = run_model();
		$display("model: %0d instructions, %0d stores", exp_steps, exp_st_count);
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		wait (done);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, the program never reached its final jump",
			LIMIT_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

//--- filelist.f
cpu_pkg.sv
cpu_dx_if.sv
cpu_regfile.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_writeback.sv
cpu.sv
cpu_assertions.sv
cpu_checker.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
	-f filelist.f -o sim_cpu &&
./obj_dir/sim_cpu | tee /dev/stderr | grep -qx "Test passed" &&
echo "run.sh: simulation passed" && exit 0 ||
{ echo "run.sh: simulation failed"; exit 1; }
